/* lc3b_defines.svh */
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

`define LC3B_WORD_W   16
`define LC3B_NUM_REGS 8
`define LC3B_RESET_PC 16'h0000

// ALU operand B select
`define ALUMUX_SR2      3'd0
`define ALUMUX_IMM5     3'd1
`define ALUMUX_OFF6_SL1 3'd2
`define ALUMUX_IMM4     3'd3
`define ALUMUX_OFF6     3'd4
`define ALUMUX_CONST8   3'd5

// Register file write data select
`define REGMUX_ALU    3'd0
`define REGMUX_MDR    3'd1
`define REGMUX_PCOFF9 3'd2
`define REGMUX_PC     3'd3
`define REGMUX_MDR_LO 3'd4
`define REGMUX_MDR_HI 3'd5

// Next PC select
`define PCMUX_PLUS2 2'd0
`define PCMUX_BRADD 2'd1
`define PCMUX_SR1   2'd2

`endif

/* lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

    // Standard LC-3b opcode encoding
    typedef enum logic [3:0] {
        op_br   = 4'd0,
        op_add  = 4'd1,
        op_ldb  = 4'd2,
        op_stb  = 4'd3,
        op_jsr  = 4'd4,
        op_and  = 4'd5,
        op_ldr  = 4'd6,
        op_str  = 4'd7,
        op_rti  = 4'd8,
        op_not  = 4'd9,
        op_ldi  = 4'd10,
        op_sti  = 4'd11,
        op_jmp  = 4'd12,
        op_shf  = 4'd13,
        op_lea  = 4'd14,
        op_trap = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } aluop_t;

    typedef enum logic [4:0] {
        s_fetch1,
        s_fetch2,
        s_fetch3,
        s_decode,
        // Register operations
        s_add,
        s_and,
        s_not,
        s_shf,
        // Control flow
        s_br,
        s_br_taken,
        s_jmp,
        s_jsr,
        s_lea,
        // Byte access
        s_calc_addr_b,
        s_ldb1,
        s_ldb2,
        s_stb1,
        s_stb2,
        // Word access
        s_calc_addr_w,
        s_ldr1,
        s_ldr2,
        s_str1,
        s_str2
    } state_t;

endpackage

`default_nettype wire

/* lc3b_ctrl_if.sv */
`default_nettype none

interface lc3b_ctrl_if;

    // Controller commands
    logic                 load_pc;
    logic                 load_ir;
    logic                 load_regfile;
    logic                 load_mar;
    logic                 load_mdr;
    logic                 load_cc;
    logic                 brmux_sel;
    logic [1:0]           pcmux_sel;
    logic                 storemux_sel;
    logic                 destmux_sel;
    logic [2:0]           alumux_sel;
    logic [2:0]           regfilemux_sel;
    logic                 marmux_sel;
    logic                 mdrmux_sel;
    lc3b_pkg::aluop_t     aluop;

    // Datapath status
    lc3b_pkg::opcode_t    opcode;
    logic                 inst4;
    logic                 inst5;
    logic                 inst11;
    logic                 branch_enable;
    logic                 mar_lsb;

    modport control (
        output load_pc, load_ir, load_regfile, load_mar, load_mdr, load_cc,
        output brmux_sel, pcmux_sel, storemux_sel, destmux_sel,
        output alumux_sel, regfilemux_sel, marmux_sel, mdrmux_sel, aluop,
        input  opcode, inst4, inst5, inst11, branch_enable, mar_lsb
    );

    modport datapath (
        input  load_pc, load_ir, load_regfile, load_mar, load_mdr, load_cc,
        input  brmux_sel, pcmux_sel, storemux_sel, destmux_sel,
        input  alumux_sel, regfilemux_sel, marmux_sel, mdrmux_sel, aluop,
        output opcode, inst4, inst5, inst11, branch_enable, mar_lsb
    );

endinterface

`default_nettype wire

/* lc3b_alu.sv */
`default_nettype none

`include "lc3b_defines.svh"

module lc3b_alu (
    input  lc3b_pkg::aluop_t          aluop,
    input  logic [`LC3B_WORD_W-1:0]   a,
    input  logic [`LC3B_WORD_W-1:0]   b,
    output logic [`LC3B_WORD_W-1:0]   f
);

    // Shift distance is the low nibble of b
    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb begin
        case (aluop)
            lc3b_pkg::alu_add:  f = a + b;
            lc3b_pkg::alu_and:  f = a & b;
            lc3b_pkg::alu_not:  f = ~a;
            lc3b_pkg::alu_pass: f = a;
            lc3b_pkg::alu_sll:  f = a << shamt;
            lc3b_pkg::alu_srl:  f = a >> shamt;
            // Sign bit fills from the left
            lc3b_pkg::alu_sra:  f = $unsigned($signed(a) >>> shamt);
            default:            f = a;
        endcase
    end

endmodule

`default_nettype wire

/* lc3b_datapath.sv */
`default_nettype none

`include "lc3b_defines.svh"

module lc3b_datapath (
    input  logic                      clk,
    input  logic                      arst_n,
    lc3b_ctrl_if.datapath             ctrl,
    output logic [`LC3B_WORD_W-1:0]   mem_address,
    output logic [`LC3B_WORD_W-1:0]   mem_wdata,
    input  logic [`LC3B_WORD_W-1:0]   mem_rdata
);

    localparam int W  = `LC3B_WORD_W;
    localparam int RW = $clog2(`LC3B_NUM_REGS);

    logic [W-1:0]  pc, ir, mar, mdr;
    logic [2:0]    nzp;
    logic [W-1:0]  regs [`LC3B_NUM_REGS];

    logic [RW-1:0] sr1_idx, dest_idx;
    logic [W-1:0]  sr1_out, sr2_out;
    logic [W-1:0]  alu_b, alu_out;
    logic [W-1:0]  br_off, br_add;
    logic [W-1:0]  pc_next, regfile_in;
    logic [2:0]    nzp_next;

    // Operand fields
    assign sr1_idx  = ctrl.storemux_sel ? ir[11:9] : ir[8:6];
    assign dest_idx = ctrl.destmux_sel ? RW'(7) : ir[11:9];
    assign sr1_out  = regs[sr1_idx];
    assign sr2_out  = regs[ir[2:0]];

    always_comb begin
        case (ctrl.alumux_sel)
            `ALUMUX_IMM5:     alu_b = {{(W-5){ir[4]}}, ir[4:0]};
            `ALUMUX_OFF6_SL1: alu_b = {{(W-7){ir[5]}}, ir[5:0], 1'b0};
            `ALUMUX_IMM4:     alu_b = {{(W-4){1'b0}}, ir[3:0]};
            `ALUMUX_OFF6:     alu_b = {{(W-6){ir[5]}}, ir[5:0]};
            `ALUMUX_CONST8:   alu_b = W'(8);
            default:          alu_b = sr2_out;
        endcase
    end

    lc3b_alu alu_i (
        .aluop (ctrl.aluop),
        .a     (sr1_out),
        .b     (alu_b),
        .f     (alu_out)
    );

    // Branch adder, offset9 for BR and LEA, offset11 for JSR
    assign br_off = ctrl.brmux_sel ? {{(W-12){ir[10]}}, ir[10:0], 1'b0}
                                   : {{(W-10){ir[8]}}, ir[8:0], 1'b0};
    assign br_add = pc + br_off;

    always_comb begin
        case (ctrl.pcmux_sel)
            `PCMUX_BRADD: pc_next = br_add;
            `PCMUX_SR1:   pc_next = sr1_out;
            default:      pc_next = pc + W'(2);
        endcase
    end

    always_comb begin
        case (ctrl.regfilemux_sel)
            `REGMUX_MDR:    regfile_in = mdr;
            `REGMUX_PCOFF9: regfile_in = br_add;
            `REGMUX_PC:     regfile_in = pc;
            `REGMUX_MDR_LO: regfile_in = {{(W-8){1'b0}}, mdr[7:0]};
            `REGMUX_MDR_HI: regfile_in = {{(W-8){1'b0}}, mdr[15:8]};
            default:        regfile_in = alu_out;
        endcase
    end

    // Flags follow the value written back
    assign nzp_next = regfile_in[W-1] ? 3'b100 :
                      (regfile_in == '0) ? 3'b010 : 3'b001;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc  <= `LC3B_RESET_PC;
            ir  <= '0;
            mar <= '0;
            mdr <= '0;
            nzp <= 3'b010;
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ctrl.load_pc) begin
                pc <= pc_next;
            end
            if (ctrl.load_ir) begin
                ir <= mdr;
            end
            if (ctrl.load_mar) begin
                mar <= ctrl.marmux_sel ? pc : alu_out;
            end
            if (ctrl.load_mdr) begin
                mdr <= ctrl.mdrmux_sel ? mem_rdata : alu_out;
            end
            if (ctrl.load_cc) begin
                nzp <= nzp_next;
            end
            if (ctrl.load_regfile) begin
                regs[dest_idx] <= regfile_in;
            end
        end
    end

    // Status back to the controller
    assign ctrl.opcode        = lc3b_pkg::opcode_t'(ir[15:12]);
    assign ctrl.inst4         = ir[4];
    assign ctrl.inst5         = ir[5];
    assign ctrl.inst11        = ir[11];
    assign ctrl.branch_enable = |(ir[11:9] & nzp);
    assign ctrl.mar_lsb       = mar[0];

    assign mem_address = mar;
    assign mem_wdata   = mdr;

endmodule

`default_nettype wire

/* lc3b_control.sv */
`default_nettype none

`include "lc3b_defines.svh"

module lc3b_control (
    input  logic          clk,
    input  logic          arst_n,
    lc3b_ctrl_if.control  ctrl,
    input  logic          mem_resp,
    output logic          mem_read,
    output logic          mem_write,
    output logic [1:0]    mem_byte_enable
);

    lc3b_pkg::state_t state, next_state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= lc3b_pkg::s_fetch1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lc3b_pkg::s_fetch1: next_state = lc3b_pkg::s_fetch2;
            lc3b_pkg::s_fetch2: begin
                if (mem_resp) begin
                    next_state = lc3b_pkg::s_fetch3;
                end
            end
            lc3b_pkg::s_fetch3: next_state = lc3b_pkg::s_decode;
            lc3b_pkg::s_decode: begin
                case (ctrl.opcode)
                    lc3b_pkg::op_add: next_state = lc3b_pkg::s_add;
                    lc3b_pkg::op_and: next_state = lc3b_pkg::s_and;
                    lc3b_pkg::op_not: next_state = lc3b_pkg::s_not;
                    lc3b_pkg::op_shf: next_state = lc3b_pkg::s_shf;
                    lc3b_pkg::op_br:  next_state = lc3b_pkg::s_br;
                    lc3b_pkg::op_jmp: next_state = lc3b_pkg::s_jmp;
                    lc3b_pkg::op_jsr: next_state = lc3b_pkg::s_jsr;
                    lc3b_pkg::op_lea: next_state = lc3b_pkg::s_lea;
                    lc3b_pkg::op_ldb,
                    lc3b_pkg::op_stb: next_state = lc3b_pkg::s_calc_addr_b;
                    lc3b_pkg::op_ldr,
                    lc3b_pkg::op_str: next_state = lc3b_pkg::s_calc_addr_w;
                    // TRAP, LDI, STI, RTI and 15 act as no-ops
                    default:          next_state = lc3b_pkg::s_fetch1;
                endcase
            end
            lc3b_pkg::s_br: begin
                next_state = ctrl.branch_enable ? lc3b_pkg::s_br_taken
                                                : lc3b_pkg::s_fetch1;
            end
            lc3b_pkg::s_calc_addr_b: begin
                next_state = (ctrl.opcode == lc3b_pkg::op_ldb) ? lc3b_pkg::s_ldb1
                                                                : lc3b_pkg::s_stb1;
            end
            lc3b_pkg::s_calc_addr_w: begin
                next_state = (ctrl.opcode == lc3b_pkg::op_ldr) ? lc3b_pkg::s_ldr1
                                                                : lc3b_pkg::s_str1;
            end
            lc3b_pkg::s_stb1: next_state = lc3b_pkg::s_stb2;
            lc3b_pkg::s_str1: next_state = lc3b_pkg::s_str2;
            lc3b_pkg::s_ldb1: begin
                if (mem_resp) begin
                    next_state = lc3b_pkg::s_ldb2;
                end
            end
            lc3b_pkg::s_ldr1: begin
                if (mem_resp) begin
                    next_state = lc3b_pkg::s_ldr2;
                end
            end
            // Memory states hold until the response
            lc3b_pkg::s_stb2,
            lc3b_pkg::s_str2: begin
                if (mem_resp) begin
                    next_state = lc3b_pkg::s_fetch1;
                end
            end
            default: next_state = lc3b_pkg::s_fetch1;
        endcase
    end

    always_comb begin
        ctrl.load_pc        = 1'b0;
        ctrl.load_ir        = 1'b0;
        ctrl.load_regfile   = 1'b0;
        ctrl.load_mar       = 1'b0;
        ctrl.load_mdr       = 1'b0;
        ctrl.load_cc        = 1'b0;
        ctrl.brmux_sel      = 1'b0;
        ctrl.pcmux_sel      = `PCMUX_PLUS2;
        ctrl.storemux_sel   = 1'b0;
        ctrl.destmux_sel    = 1'b0;
        ctrl.alumux_sel     = `ALUMUX_SR2;
        ctrl.regfilemux_sel = `REGMUX_ALU;
        ctrl.marmux_sel     = 1'b0;
        ctrl.mdrmux_sel     = 1'b0;
        ctrl.aluop          = lc3b_pkg::alu_add;
        mem_read            = 1'b0;
        mem_write           = 1'b0;
        mem_byte_enable     = 2'b11;

        case (state)
            lc3b_pkg::s_fetch1: begin
                // MAR gets PC, PC advances
                ctrl.marmux_sel = 1'b1;
                ctrl.load_mar   = 1'b1;
                ctrl.load_pc    = 1'b1;
            end
            lc3b_pkg::s_fetch2,
            lc3b_pkg::s_ldb1,
            lc3b_pkg::s_ldr1: begin
                mem_read        = 1'b1;
                ctrl.mdrmux_sel = 1'b1;
                ctrl.load_mdr   = 1'b1;
            end
            lc3b_pkg::s_fetch3: ctrl.load_ir = 1'b1;
            lc3b_pkg::s_add,
            lc3b_pkg::s_and,
            lc3b_pkg::s_not: begin
                ctrl.alumux_sel   = ctrl.inst5 ? `ALUMUX_IMM5 : `ALUMUX_SR2;
                ctrl.aluop        = (state == lc3b_pkg::s_add) ? lc3b_pkg::alu_add :
                                    (state == lc3b_pkg::s_and) ? lc3b_pkg::alu_and :
                                                                 lc3b_pkg::alu_not;
                ctrl.load_cc      = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            lc3b_pkg::s_shf: begin
                ctrl.alumux_sel   = `ALUMUX_IMM4;
                ctrl.aluop        = !ctrl.inst4 ? lc3b_pkg::alu_sll :
                                    !ctrl.inst5 ? lc3b_pkg::alu_srl : lc3b_pkg::alu_sra;
                ctrl.load_cc      = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            lc3b_pkg::s_br_taken: begin
                ctrl.pcmux_sel = `PCMUX_BRADD;
                ctrl.load_pc   = 1'b1;
            end
            lc3b_pkg::s_jmp: begin
                ctrl.pcmux_sel = `PCMUX_SR1;
                ctrl.load_pc   = 1'b1;
            end
            lc3b_pkg::s_jsr: begin
                // Link to R7 and jump in the same cycle
                ctrl.regfilemux_sel = `REGMUX_PC;
                ctrl.destmux_sel    = 1'b1;
                ctrl.load_regfile   = 1'b1;
                ctrl.brmux_sel      = 1'b1;
                ctrl.pcmux_sel      = ctrl.inst11 ? `PCMUX_BRADD : `PCMUX_SR1;
                ctrl.load_pc        = 1'b1;
            end
            lc3b_pkg::s_lea: begin
                ctrl.regfilemux_sel = `REGMUX_PCOFF9;
                ctrl.load_cc        = 1'b1;
                ctrl.load_regfile   = 1'b1;
            end
            lc3b_pkg::s_calc_addr_b,
            lc3b_pkg::s_calc_addr_w: begin
                ctrl.alumux_sel = (state == lc3b_pkg::s_calc_addr_b) ? `ALUMUX_OFF6
                                                                     : `ALUMUX_OFF6_SL1;
                ctrl.load_mar   = 1'b1;
            end
            lc3b_pkg::s_ldb2: begin
                ctrl.regfilemux_sel = ctrl.mar_lsb ? `REGMUX_MDR_HI : `REGMUX_MDR_LO;
                ctrl.load_cc        = 1'b1;
                ctrl.load_regfile   = 1'b1;
            end
            lc3b_pkg::s_ldr2: begin
                ctrl.regfilemux_sel = `REGMUX_MDR;
                ctrl.load_cc        = 1'b1;
                ctrl.load_regfile   = 1'b1;
            end
            lc3b_pkg::s_stb1,
            lc3b_pkg::s_str1: begin
                // Store source through the ALU, odd bytes move to the high lane
                ctrl.storemux_sel = 1'b1;
                ctrl.alumux_sel   = `ALUMUX_CONST8;
                ctrl.aluop        = (state == lc3b_pkg::s_stb1 && ctrl.mar_lsb) ?
                                    lc3b_pkg::alu_sll : lc3b_pkg::alu_pass;
                ctrl.load_mdr     = 1'b1;
            end
            lc3b_pkg::s_stb2: begin
                mem_write       = 1'b1;
                mem_byte_enable = ctrl.mar_lsb ? 2'b10 : 2'b01;
            end
            lc3b_pkg::s_str2: mem_write = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* lc3b_cpu.sv */
`default_nettype none

`include "lc3b_defines.svh"

module lc3b_cpu (
    input  logic                      clk,
    input  logic                      arst_n,
    output logic [`LC3B_WORD_W-1:0]   mem_address,
    output logic [`LC3B_WORD_W-1:0]   mem_wdata,
    input  logic [`LC3B_WORD_W-1:0]   mem_rdata,
    input  logic                      mem_resp,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic [1:0]                mem_byte_enable
);

    // Commands and status between controller and datapath
    lc3b_ctrl_if ctrl_bus ();

    lc3b_control control_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .ctrl            (ctrl_bus.control),
        .mem_resp        (mem_resp),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable)
    );

    lc3b_datapath datapath_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .ctrl        (ctrl_bus.datapath),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata)
    );

endmodule

`default_nettype wire

/* lc3b_checker.sv */
`default_nettype none

module lc3b_checker (
    input logic             clk,
    input logic             arst_n,
    input logic             mem_read,
    input logic             mem_write,
    input logic             mem_resp,
    input lc3b_pkg::state_t state
);

    int unsigned fail_count = 0;

    rw_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_read && mem_write))
    else begin
        $error("mem_read and mem_write are high in the same cycle");
        fail_count++;
    end

    // Request level holds until the response
    request_held: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_read || mem_write) && !mem_resp |=> $stable({mem_read, mem_write}))
    else begin
        $error("memory request dropped or changed before mem_resp");
        fail_count++;
    end

    state_legal: assert property (@(posedge clk)
        !$isunknown(state) && state <= lc3b_pkg::s_str2)
    else begin
        $error("controller state outside the enum");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !(mem_read || mem_write))
    else begin
        $error("memory request while reset is asserted");
        fail_count++;
    end

endmodule

`default_nettype wire

/* lc3b_store_mon.sv */
`default_nettype none

`include "lc3b_defines.svh"

module lc3b_store_mon #(
    parameter int NUM_STORES = 16
) (
    input  logic                      clk,
    input  logic                      mem_write,
    input  logic                      mem_resp,
    input  logic [`LC3B_WORD_W-1:0]   mem_address,
    input  logic [`LC3B_WORD_W-1:0]   mem_wdata,
    input  logic [1:0]                mem_byte_enable,
    input  logic [33:0]               exp_stores [NUM_STORES],
    output int                        store_count,
    output int                        mismatch_count,
    output int                        extra_count
);

    logic [15:0] exp_addr;
    logic [15:0] exp_data;
    logic [15:0] lane_mask;
    logic [1:0]  exp_be;

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    // A write commits in the cycle where mem_resp is high
    always @(posedge clk) begin
        if (mem_write && mem_resp) begin
            if (store_count < NUM_STORES) begin
                exp_addr  = exp_stores[store_count][33:18];
                exp_data  = exp_stores[store_count][17:2];
                exp_be    = exp_stores[store_count][1:0];
                // Only enabled lanes carry data
                lane_mask = {{8{exp_be[1]}}, {8{exp_be[0]}}};
                compare_value("mem_address", exp_addr, mem_address);
                compare_value("mem_byte_enable", {14'd0, exp_be}, {14'd0, mem_byte_enable});
                compare_value("mem_wdata", exp_data & lane_mask, mem_wdata & lane_mask);
            end else begin
                $display("Extra store at time %0t to address %h beyond the expected list",
                         $time, mem_address);
                extra_count++;
            end
            store_count++;
        end
    end

endmodule

`default_nettype wire

/* tb_lc3b_cpu.sv */
`default_nettype none

`include "lc3b_defines.svh"

module tb_lc3b_cpu;

    localparam int RESET_CYCLES    = 5;
    localparam int PROG_ROWS       = 48;
    localparam int NUM_STORES      = 16;
    localparam int DRAIN_CYCLES    = 40;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + PROG_ROWS * 12 * 4;

    logic                    clk;
    logic                    arst_n;
    logic [`LC3B_WORD_W-1:0] mem_address;
    logic [`LC3B_WORD_W-1:0] mem_wdata;
    logic [`LC3B_WORD_W-1:0] mem_rdata;
    logic                    mem_resp;
    logic                    mem_read;
    logic                    mem_write;
    logic [1:0]              mem_byte_enable;

    logic [`LC3B_WORD_W-1:0] mem [256];
    logic                    busy;
    logic [1:0]              wait_left;
    logic [31:0]             rnd;
    integer                  seed;
    int                      store_count;
    int                      mismatch_count;
    int                      extra_count;

    // Program and data image as {byte address, word}
    logic [31:0] prog [PROG_ROWS] = '{
        // R6 = 0x0100 store base, R1 = 13, R2 = -13, ADD register form
        {16'h0000, 16'h1c21}, {16'h0002, 16'hdd88}, {16'h0004, 16'h122d},
        {16'h0006, 16'h1433}, {16'h0008, 16'h1841}, {16'h000a, 16'h7980},
        // AND imm and register, NOT
        {16'h000c, 16'h5866}, {16'h000e, 16'h7981}, {16'h0010, 16'h5881},
        {16'h0012, 16'h7982}, {16'h0014, 16'h987f}, {16'h0016, 16'h7983},
        // SLL 4, SRL 4, SRA 2 of -13
        {16'h0018, 16'hd884}, {16'h001a, 16'h7984}, {16'h001c, 16'hd894},
        {16'h001e, 16'h7985}, {16'h0020, 16'hd8b2}, {16'h0022, 16'h7986},
        // Zero result, BRp falls through, BRz skips a store
        {16'h0024, 16'h1642}, {16'h0026, 16'h0201}, {16'h0028, 16'h0401},
        {16'h002a, 16'h739f}, {16'h002c, 16'h7787},
        // LEA then JMP over a store
        {16'h002e, 16'hea02}, {16'h0030, 16'hc140}, {16'h0032, 16'h739f},
        {16'h0034, 16'h7b88},
        // JSR and JSRR, R7 stored
        {16'h0036, 16'h4802}, {16'h0038, 16'h739f}, {16'h003a, 16'h739f},
        {16'h003c, 16'h7f89}, {16'h003e, 16'hea03}, {16'h0040, 16'h4140},
        {16'h0042, 16'h739f}, {16'h0044, 16'h739f}, {16'h0046, 16'h7f8a},
        // LDR, LDB even and odd, STB even and odd
        {16'h0048, 16'hea3b}, {16'h004a, 16'h6940}, {16'h004c, 16'h798b},
        {16'h004e, 16'h2942}, {16'h0050, 16'h798c}, {16'h0052, 16'h2943},
        {16'h0054, 16'h798d}, {16'h0056, 16'h399c}, {16'h0058, 16'h359f},
        // Branch to itself, then the load data
        {16'h005a, 16'h0fff}, {16'h00c0, 16'hbeef}, {16'h00c2, 16'h8c47}
    };

    // Expected stores as {byte address, data, byte enable}
    logic [33:0] exp_stores [NUM_STORES] = '{
        {16'h0100, 16'h001a, 2'b11}, {16'h0102, 16'h0004, 2'b11},
        {16'h0104, 16'h0001, 2'b11}, {16'h0106, 16'hfff2, 2'b11},
        {16'h0108, 16'hff30, 2'b11}, {16'h010a, 16'h0fff, 2'b11},
        {16'h010c, 16'hfffc, 2'b11}, {16'h010e, 16'h0000, 2'b11},
        {16'h0110, 16'h0034, 2'b11}, {16'h0112, 16'h0038, 2'b11},
        {16'h0114, 16'h0042, 2'b11}, {16'h0116, 16'hbeef, 2'b11},
        {16'h0118, 16'h0047, 2'b11}, {16'h011a, 16'h008c, 2'b11},
        {16'h011c, 16'h008c, 2'b01}, {16'h011f, 16'hf300, 2'b10}
    };

    lc3b_cpu lc3b_cpu_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable)
    );

    bind lc3b_cpu lc3b_checker checker_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_resp  (mem_resp),
        .state     (control_i.state)
    );

    lc3b_store_mon #(
        .NUM_STORES (NUM_STORES)
    ) store_mon_i (
        .clk             (clk),
        .mem_write       (mem_write),
        .mem_resp        (mem_resp),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .exp_stores      (exp_stores),
        .store_count     (store_count),
        .mismatch_count  (mismatch_count),
        .extra_count     (extra_count)
    );

    always #5 clk = ~clk;

    // Memory with a random 0 to 3 cycle wait before each response
    always @(posedge clk) begin
        mem_resp <= 1'b0;
        if (arst_n && (mem_read || mem_write) && !mem_resp) begin
            if (!busy) begin
                rnd = $random(seed);
                wait_left <= rnd[1:0];
                busy      <= 1'b1;
            end else if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                busy     <= 1'b0;
                mem_resp <= 1'b1;
                if (mem_read) begin
                    mem_rdata <= mem[mem_address[8:1]];
                end else begin
                    if (mem_byte_enable[0]) begin
                        mem[mem_address[8:1]][7:0] <= mem_wdata[7:0];
                    end
                    if (mem_byte_enable[1]) begin
                        mem[mem_address[8:1]][15:8] <= mem_wdata[15:8];
                    end
                end
            end
        end
    end

    initial begin
        seed = 32'hdd72_9300;
        clk = 1'b0;
        arst_n    <= 1'b0;
        mem_resp  <= 1'b0;
        mem_rdata <= '0;
        busy      <= 1'b0;
        wait_left <= 2'd0;
        // Unused words decode as opcode 15
        for (int i = 0; i < 256; i++) begin
            mem[i] <= {8'hf0, i[7:0]};
        end
        for (int r = 0; r < PROG_ROWS; r++) begin
            mem[prog[r][24:17]] <= prog[r][15:0];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        wait (store_count == NUM_STORES);
        // Give a stray store time to show up
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("Stores %0d of %0d, value errors %0d, extra stores %0d, assertion failures %0d",
                 store_count, NUM_STORES, mismatch_count, extra_count,
                 lc3b_cpu_i.checker_i.fail_count);
        if (mismatch_count + extra_count + lc3b_cpu_i.checker_i.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Timeout after %0d cycles, %0d of %0d expected stores are missing",
                 WATCHDOG_CYCLES, NUM_STORES - store_count, NUM_STORES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
lc3b_pkg.sv
lc3b_ctrl_if.sv
lc3b_alu.sv
lc3b_datapath.sv
lc3b_control.sv
lc3b_cpu.sv
lc3b_checker.sv
lc3b_store_mon.sv
tb_lc3b_cpu.sv

/* Bender.yml */
package:
  name: lc3b_cpu

sources:
  - include_dirs:
      - .
    files:
      - lc3b_pkg.sv
      - lc3b_ctrl_if.sv
      - lc3b_alu.sv
      - lc3b_datapath.sv
      - lc3b_control.sv
      - lc3b_cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - lc3b_checker.sv
      - lc3b_store_mon.sv
      - tb_lc3b_cpu.sv
